//--- cmd_link_pkg.sv
package cmd_link_pkg;

   // Frame header, first and second byte on the wire.
   parameter logic [7:0] hdr_byte0 = 8'hF5;
   parameter logic [7:0] hdr_byte1 = 8'h08;

   // Kind byte, six body bytes, checksum byte.
   parameter int payload_bytes = 8;

   parameter logic [7:0] kind_reg_write = 8'h01;
   parameter logic [7:0] kind_tune      = 8'h02;

   // Register write view of the body.
   typedef struct packed {
      logic [15:0] addr;
      logic [31:0] data;
   } reg_view_t;

   // Tuner view of the body.
   typedef struct packed {
      logic [7:0]  channel;
      logic [7:0]  gain;
      logic [31:0] freq;
   } tune_view_t;

   // 48-bit body, read according to the kind byte.
   typedef union packed {
      reg_view_t  reg_view;
      tune_view_t tune_view;
   } cmd_body_u;

   typedef struct packed {
      logic [7:0] kind;
      cmd_body_u  body;
   } cmd_t;

   // Realigned payload byte from the aligner.
   typedef struct packed {
      logic       valid;
      logic       first;   // Payload byte 0.
      logic [7:0] data;
   } pay_byte_t;

   // Both counts stop at 8'hFF.
   typedef struct packed {
      logic [7:0] csum_errs;
      logic [7:0] overflows;
   } rx_stats_t;

endpackage

//--- frame_aligner.sv
`timescale 1ns/1ps

module frame_aligner
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    rx_en,
   input  logic [7:0]              rx_data,
   output cmd_link_pkg::pay_byte_t pay
);

   localparam int cnt_w = $clog2(cmd_link_pkg::payload_bytes);
   localparam int last_cnt = cmd_link_pkg::payload_bytes - 1;

   // Byte history, h0 is the newest.
   logic [7:0]       h0;
   logic [7:0]       h1;
   logic [7:0]       h2;
   logic [23:0]      win;
   logic [15:0]      pair;

   logic             lock;
   logic [2:0]       shift;
   logic [cnt_w-1:0] byte_cnt;

   logic             hit;
   logic [2:0]       hit_shift;
   logic [7:0]       aligned;

   logic             pay_valid;
   logic             pay_first;
   logic [7:0]       pay_data;

   assign win  = {h2, h1, h0};
   assign pair = {h1, h0};

   always_ff @(posedge clk)
   begin
      if (rst || !rx_en)
      begin
         h0 <= 8'h00;
         h1 <= 8'h00;
         h2 <= 8'h00;
      end
      else
      begin
         h0 <= rx_data;
         h1 <= h0;
         h2 <= h1;
      end
   end

   // Header search over all bit offsets.
   always_comb
   begin
      hit       = 1'b0;
      hit_shift = 3'd0;
      for (int s = 7; s >= 0; s--)
      begin
         // Lowest offset is checked last and wins.
         if (win[23 - s -: 16] == {cmd_link_pkg::hdr_byte0, cmd_link_pkg::hdr_byte1})
         begin
            hit       = 1'b1;
            hit_shift = 3'(s);
         end
      end
   end

   // Payload byte straddles the older and newer history byte.
   assign aligned = pair[15 - shift -: 8];

   always_ff @(posedge clk)
   begin
      if (rst || !rx_en)
      begin
         lock     <= 1'b0;
         shift    <= 3'd0;
         byte_cnt <= '0;
      end
      else if (!lock)
      begin
         byte_cnt <= '0;
         if (hit)
         begin
            lock  <= 1'b1;
            shift <= hit_shift;
         end
      end
      else
      begin
         byte_cnt <= byte_cnt + 1'b1;
         if (byte_cnt == cnt_w'(last_cnt))
         begin
            lock  <= 1'b0;   // Back to search.
            shift <= 3'd0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || !rx_en)
      begin
         pay_valid <= 1'b0;
         pay_first <= 1'b0;
      end
      else
      begin
         pay_valid <= lock;
         pay_first <= lock && byte_cnt == '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (lock)
      begin
         pay_data <= aligned;
      end
   end

   assign pay.valid = pay_valid;
   assign pay.first = pay_first;
   assign pay.data  = pay_data;

endmodule

//--- cmd_frame_parser.sv
`timescale 1ns/1ps

module cmd_frame_parser
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    rx_en,
   input  cmd_link_pkg::pay_byte_t pay,
   output logic                    cmd_push,
   output cmd_link_pkg::cmd_t      cmd,
   output logic                    csum_err
);

   localparam int idx_w = $clog2(cmd_link_pkg::payload_bytes);
   localparam int last_idx = cmd_link_pkg::payload_bytes - 1;

   logic             busy;
   logic [idx_w-1:0] idx;      // Next payload byte expected.
   logic [7:0]       kind_q;
   logic [47:0]      body_sr;
   logic [7:0]       csum_acc;

   logic             start;
   logic             take_body;
   logic             take_csum;
   logic             csum_ok;

   assign start     = pay.valid && pay.first;
   assign take_body = busy && pay.valid && !pay.first && idx != idx_w'(last_idx);
   assign take_csum = busy && pay.valid && !pay.first && idx == idx_w'(last_idx);
   assign csum_ok   = csum_acc == pay.data;

   always_ff @(posedge clk)
   begin
      if (rst || !rx_en)
      begin
         busy <= 1'b0;
         idx  <= '0;
      end
      else if (start)
      begin
         busy <= 1'b1;   // Restart on every first mark.
         idx  <= idx_w'(1);
      end
      else if (take_body)
      begin
         idx <= idx + 1'b1;
      end
      else if (take_csum)
      begin
         busy <= 1'b0;
         idx  <= '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cmd_push <= 1'b0;
         csum_err <= 1'b0;
      end
      else
      begin
         cmd_push <= rx_en && take_csum && csum_ok;
         csum_err <= rx_en && take_csum && !csum_ok;
      end
   end

   // First body byte ends up most significant.
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         kind_q   <= pay.data;
         csum_acc <= pay.data;
      end
      else if (take_body)
      begin
         body_sr  <= {body_sr[39:0], pay.data};
         csum_acc <= csum_acc ^ pay.data;
      end
   end

   // Unknown kinds pass through unchanged.
   always_ff @(posedge clk)
   begin
      if (take_csum)
      begin
         cmd.kind <= kind_q;
         cmd.body <= cmd_link_pkg::cmd_body_u'(body_sr);
      end
   end

endmodule

//--- cmd_credit_queue.sv
`timescale 1ns/1ps

module cmd_credit_queue
#(
   parameter int QUEUE_DEPTH  = 4,
   parameter int HOST_CREDITS = 2
)
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cmd_push,
   input  cmd_link_pkg::cmd_t      cmd_in,
   input  logic                    csum_err,
   input  logic                    credit_return,
   output logic                    cmd_valid,
   output cmd_link_pkg::cmd_t      cmd_out,
   output cmd_link_pkg::rx_stats_t stats
);

   localparam int ptr_w  = QUEUE_DEPTH > 1 ? $clog2(QUEUE_DEPTH) : 1;
   localparam int lvl_w  = $clog2(QUEUE_DEPTH + 1);
   localparam int cred_w = $clog2(HOST_CREDITS + 1);

   cmd_link_pkg::cmd_t mem [QUEUE_DEPTH];

   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   logic [lvl_w-1:0]  level;
   logic [cred_w-1:0] credits;
   logic [cred_w:0]   credit_sum;

   logic              full;
   logic              push_ok;
   logic              send;

   assign full    = level == lvl_w'(QUEUE_DEPTH);
   assign push_ok = cmd_push && !full;
   assign send    = level != '0 && credits != '0;   // One transfer per credit.

   // Spend and return may land together.
   assign credit_sum = {1'b0, credits} + (cred_w + 1)'(credit_return)
                       - (cred_w + 1)'(send);

   always_ff @(posedge clk)
   begin
      if (push_ok)
      begin
         mem[wr_ptr] <= cmd_in;
      end
      if (send)
      begin
         cmd_out <= mem[rd_ptr];
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         level     <= '0;
         cmd_valid <= 1'b0;
         credits   <= cred_w'(HOST_CREDITS);
      end
      else
      begin
         if (push_ok)
         begin
            wr_ptr <= wr_ptr == ptr_w'(QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (send)
         begin
            rd_ptr <= rd_ptr == ptr_w'(QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         level     <= level + lvl_w'(push_ok) - lvl_w'(send);
         cmd_valid <= send;
         if (credit_sum > (cred_w + 1)'(HOST_CREDITS))
            credits <= cred_w'(HOST_CREDITS);   // Clamp stray returns.
         else
            credits <= credit_sum[cred_w-1:0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         stats <= '0;
      end
      else
      begin
         if (csum_err && stats.csum_errs != 8'hFF)
            stats.csum_errs <= stats.csum_errs + 8'd1;
         if (cmd_push && full && stats.overflows != 8'hFF)
            stats.overflows <= stats.overflows + 8'd1;   // Dropped on full.
      end
   end

endmodule

//--- cmd_rx_top.sv
`timescale 1ns/1ps

module cmd_rx_top
#(
   parameter int QUEUE_DEPTH  = 4,
   parameter int HOST_CREDITS = 2
)
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    rx_en,
   input  logic [7:0]              rx_data,
   input  logic                    credit_return,
   output logic                    cmd_valid,
   output cmd_link_pkg::cmd_t      cmd_out,
   output cmd_link_pkg::rx_stats_t stats
);

   cmd_link_pkg::pay_byte_t pay;
   cmd_link_pkg::cmd_t      cmd;
   logic                    cmd_push;
   logic                    csum_err;

   frame_aligner u_frame_aligner
   (
      .clk     (clk),
      .rst     (rst),
      .rx_en   (rx_en),
      .rx_data (rx_data),
      .pay     (pay)
   );

   cmd_frame_parser u_cmd_frame_parser
   (
      .clk      (clk),
      .rst      (rst),
      .rx_en    (rx_en),
      .pay      (pay),
      .cmd_push (cmd_push),
      .cmd      (cmd),
      .csum_err (csum_err)
   );

   cmd_credit_queue
   #(
      .QUEUE_DEPTH  (QUEUE_DEPTH),
      .HOST_CREDITS (HOST_CREDITS)
   )
   u_cmd_credit_queue
   (
      .clk           (clk),
      .rst           (rst),
      .cmd_push      (cmd_push),
      .cmd_in        (cmd),
      .csum_err      (csum_err),
      .credit_return (credit_return),
      .cmd_valid     (cmd_valid),
      .cmd_out       (cmd_out),
      .stats         (stats)
   );

endmodule

//--- tb_cmd_rx.sv
`timescale 1ns/1ps

module tb_cmd_rx;

   localparam int QUEUE_DEPTH    = 4;
   localparam int HOST_CREDITS   = 2;
   localparam int n_rows         = 19;
   localparam int stream_bytes   = 20;
   localparam int timeout_cycles = n_rows * 40 + 200;

   typedef struct packed {
      logic [2:0]  offset;
      logic [7:0]  kind;
      logic [47:0] body;
      logic        corrupt;
      logic        hold;
      logic        abort;
   } frame_row_t;

   logic                    clk;
   logic                    rst = 1'b1;
   logic                    rx_en = 1'b0;
   logic [7:0]              rx_data = 8'h00;
   logic                    credit_return = 1'b0;
   logic                    cmd_valid;
   cmd_link_pkg::cmd_t      cmd_out;
   cmd_link_pkg::rx_stats_t stats;

   frame_row_t  rows[$];
   logic [55:0] expect_q[$];   // Kind and body, oldest first.
   logic [55:0] exp_cmd;
   logic        hold = 1'b0;   // Host keeps its credits.
   integer      seed;
   int          errors = 0;
   int          seen_cnt = 0;
   int          owed = 0;
   int          cycle_cnt = 0;
   int          tests_run = 0;
   int          tests_passed = 0;

   cmd_rx_top
   #(
      .QUEUE_DEPTH  (QUEUE_DEPTH),
      .HOST_CREDITS (HOST_CREDITS)
   )
   u_cmd_rx_top
   (
      .clk           (clk),
      .rst           (rst),
      .rx_en         (rx_en),
      .rx_data       (rx_data),
      .credit_return (credit_return),
      .cmd_valid     (cmd_valid),
      .cmd_out       (cmd_out),
      .stats         (stats)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Kind, six body bytes and checksum as sent on the wire.
   function automatic logic [63:0] payload_of(input frame_row_t r);
      logic [7:0] csum;
      csum = r.kind;
      for (int i = 0; i < 6; i++)
      begin
         csum = csum ^ r.body[47 - 8 * i -: 8];
      end
      if (r.corrupt)
      begin
         csum = csum ^ 8'h10;
      end
      return {r.kind, r.body, csum};
   endfunction

   // Payload bits that could pass for a header after the lock ends.
   function automatic logic has_false_hdr(input frame_row_t r);
      logic [87:0] bits;
      bits = {payload_of(r), 24'h000000};
      for (int p = 0; p <= 72; p++)
      begin
         if (bits[87 - p -: 16] == {cmd_link_pkg::hdr_byte0, cmd_link_pkg::hdr_byte1})
         begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   function automatic logic [159:0] build_stream(input frame_row_t r);
      logic [159:0] bits;
      bits = {16'h0000, cmd_link_pkg::hdr_byte0, cmd_link_pkg::hdr_byte1,
              payload_of(r), 64'h0};
      return bits >> r.offset;   // Zero fill ahead of the header.
   endfunction

   task automatic add_row(input logic [2:0] offset, input logic [7:0] kind,
                          input logic corrupt, input logic hold_row, input logic abort);
      frame_row_t  r;
      logic [31:0] hi;
      logic [31:0] lo;
      r.offset  = offset;
      r.kind    = kind;
      r.corrupt = corrupt;
      r.hold    = hold_row;
      r.abort   = abort;
      do
      begin
         hi     = $random(seed);
         lo     = $random(seed);
         r.body = {hi[15:0], lo};
      end
      while (has_false_hdr(r));
      rows.push_back(r);
   endtask

   task automatic send_frame(input frame_row_t r);
      logic [159:0] bits;
      bits = build_stream(r);
      for (int i = 0; i < stream_bytes; i++)
      begin
         @(posedge clk);
         rx_data <= bits[159 - 8 * i -: 8];
         rx_en   <= !(r.abort && i == 8);   // Drop mid payload.
      end
   endtask

   task automatic wait_drain;
      while (expect_q.size() != 0)
      begin
         @(posedge clk);
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before)
      begin
         tests_passed++;
         $display("%s: pass", name);
      end
      else
         $display("%s: fail, %0d check(s) failed", name, errors - err_before);
   endtask

   task automatic release_credits;
      int err_before;
      err_before = errors;
      hold <= 1'b0;
      wait_drain();
      report_test("credit release and queue drain", err_before);
   endtask

   // Host side, one credit back per transfer.
   always @(posedge clk)
   begin
      if (rst)
      begin
         credit_return <= 1'b0;
         owed = 0;
      end
      else
      begin
         if (cmd_valid)
            owed = owed + 1;
         if (!hold && owed > 0)
         begin
            credit_return <= 1'b1;
            owed = owed - 1;
         end
         else
            credit_return <= 1'b0;
      end
   end

   always @(posedge clk)
   begin
      if (!rst && cmd_valid)
      begin
         seen_cnt++;
         assert (expect_q.size() != 0)
         else
         begin
            $display("unexpected command %h on cmd_out, none was expected", cmd_out);
            errors++;
         end
         if (expect_q.size() != 0)
         begin
            exp_cmd = expect_q.pop_front();
            assert (cmd_out == exp_cmd)
            else
            begin
               $display("MISMATCH cmd_out: got %h, expected %h", cmd_out, exp_cmd);
               errors++;
            end
            if (exp_cmd[55:48] == cmd_link_pkg::kind_reg_write)
            begin
               assert (cmd_out.body.reg_view.addr == exp_cmd[47:32])
               else
               begin
                  $display("MISMATCH reg_view.addr: got %h, expected %h",
                           cmd_out.body.reg_view.addr, exp_cmd[47:32]);
                  errors++;
               end
               assert (cmd_out.body.reg_view.data == exp_cmd[31:0])
               else
               begin
                  $display("MISMATCH reg_view.data: got %h, expected %h",
                           cmd_out.body.reg_view.data, exp_cmd[31:0]);
                  errors++;
               end
            end
            else if (exp_cmd[55:48] == cmd_link_pkg::kind_tune)
            begin
               assert (cmd_out.body.tune_view.channel == exp_cmd[47:40] &&
                       cmd_out.body.tune_view.gain == exp_cmd[39:32] &&
                       cmd_out.body.tune_view.freq == exp_cmd[31:0])
               else
               begin
                  $display("MISMATCH tune_view: got %h, expected %h",
                           cmd_out.body.tune_view, exp_cmd[47:0]);
                  errors++;
               end
            end
         end
      end
   end

   initial
   begin
      while (cycle_cnt < timeout_cycles)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      frame_row_t r;
      logic [7:0] csum_before;
      logic [7:0] ovf_before;
      logic [7:0] exp_csum;
      logic [7:0] exp_ovf;
      logic       dropped;
      int         err_before;
      int         held;
      int         hold_base;
      seed      = 32'h9e4a124b;
      held      = 0;
      hold_base = 0;
      // Offset, kind, corrupt, hold, abort.
      add_row(3'd0, cmd_link_pkg::kind_reg_write, 1'b0, 1'b0, 1'b0);
      add_row(3'd1, cmd_link_pkg::kind_tune,      1'b0, 1'b0, 1'b0);
      add_row(3'd2, cmd_link_pkg::kind_reg_write, 1'b0, 1'b0, 1'b0);
      add_row(3'd3, cmd_link_pkg::kind_tune,      1'b0, 1'b0, 1'b0);
      add_row(3'd4, cmd_link_pkg::kind_reg_write, 1'b0, 1'b0, 1'b0);
      add_row(3'd5, cmd_link_pkg::kind_tune,      1'b0, 1'b0, 1'b0);
      add_row(3'd6, cmd_link_pkg::kind_reg_write, 1'b0, 1'b0, 1'b0);
      add_row(3'd7, cmd_link_pkg::kind_tune,      1'b0, 1'b0, 1'b0);
      add_row(3'd4, 8'h5A,                        1'b0, 1'b0, 1'b0);   // Unknown kind.
      add_row(3'd3, cmd_link_pkg::kind_reg_write, 1'b1, 1'b0, 1'b0);
      add_row(3'd5, cmd_link_pkg::kind_tune,      1'b0, 1'b0, 1'b1);
      add_row(3'd2, cmd_link_pkg::kind_reg_write, 1'b0, 1'b0, 1'b0);
      add_row(3'd1, cmd_link_pkg::kind_reg_write, 1'b0, 1'b1, 1'b0);
      add_row(3'd6, cmd_link_pkg::kind_tune,      1'b0, 1'b1, 1'b0);
      add_row(3'd0, cmd_link_pkg::kind_reg_write, 1'b0, 1'b1, 1'b0);
      add_row(3'd7, cmd_link_pkg::kind_tune,      1'b0, 1'b1, 1'b0);
      add_row(3'd3, cmd_link_pkg::kind_reg_write, 1'b0, 1'b1, 1'b0);
      add_row(3'd5, cmd_link_pkg::kind_tune,      1'b0, 1'b1, 1'b0);
      add_row(3'd2, cmd_link_pkg::kind_reg_write, 1'b0, 1'b1, 1'b0);   // Overflows.
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < n_rows; i++)
      begin
         r = rows[i];
         if (hold && !r.hold)
         begin
            release_credits();
            held = 0;
         end
         err_before  = errors;
         csum_before = stats.csum_errs;
         ovf_before  = stats.overflows;
         if (r.hold && !hold)
            hold_base = seen_cnt;
         dropped = 1'b0;
         if (!r.corrupt && !r.abort)
         begin
            if (r.hold)
            begin
               dropped = held >= QUEUE_DEPTH + HOST_CREDITS;
               held++;
            end
            if (!dropped)
               expect_q.push_back({r.kind, r.body});
         end
         hold <= r.hold;
         send_frame(r);
         if (!r.hold)
            wait_drain();
         exp_csum = csum_before + (r.corrupt ? 8'd1 : 8'd0);
         exp_ovf  = ovf_before + (dropped ? 8'd1 : 8'd0);
         assert (stats.csum_errs == exp_csum)
         else
         begin
            $display("MISMATCH stats.csum_errs: got %h, expected %h", stats.csum_errs, exp_csum);
            errors++;
         end
         assert (stats.overflows == exp_ovf)
         else
         begin
            $display("MISMATCH stats.overflows: got %h, expected %h", stats.overflows, exp_ovf);
            errors++;
         end
         assert (!r.hold || seen_cnt - hold_base <= HOST_CREDITS)
         else
         begin
            $display("more commands sent than credits allowed while credits were held");
            errors++;
         end
         report_test($sformatf("row %0d offset %0d kind %h", i, r.offset, r.kind), err_before);
      end
      if (hold)
         release_credits();
      repeat (10) @(posedge clk);   // Catch stray commands.
      $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
               tests_run, tests_passed, tests_run - tests_passed, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- compile.f
cmd_link_pkg.sv
frame_aligner.sv
cmd_frame_parser.sv
cmd_credit_queue.sv
cmd_rx_top.sv
tb_cmd_rx.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run, from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cmd_rx \
   -f compile.f -o tb_cmd_rx
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_cmd_rx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0
